//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing
TOP       := tb_smpc_pad
FLIST     := flist.f
OBJ_DIR   := obj_dir

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FLIST)) include/smpc_pad_cfg.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_smpc_pad.sv
`timescale 1ns/1ps
`include "smpc_pad_cfg.svh"

module tb_smpc_pad import smpc_pad_pkg::*; ();

	// Roughly twice the stimulus length of about 1900 cycles
	localparam int CYCLE_LIMIT = 4000;

	logic CLK;
	logic RST_N;
	logic SMPC_CE;
	logic [`PAD_PIN_W-1:0] pdr_o [2];
	logic [`PAD_PIN_W-1:0] ddr [2];
	logic [`PAD_BTN_W-1:0] joy [2];
	logic [`PAD_AXIS_W-1:0] jx [2];
	logic [`PAD_AXIS_W-1:0] jy [2];
	pad_type_e jtype [2];
	logic [`PAD_PIN_W-1:0] PDR1I;
	logic [`PAD_PIN_W-1:0] PDR2I;

	// Reference model state and advance count per port
	int adv_cnt [2];
	logic m_tl [2];
	logic [`PAD_NIB_W-1:0] m_nib [2];
	logic [`PAD_PIN_W-1:0] exp_pin [2];

	integer seed;
	int pin_errors;
	int nib_errors;
	int cycles;

	smpc_pad_top u_dut (
		.CLK(CLK), .RST_N(RST_N), .SMPC_CE(SMPC_CE),
		.PDR1O(pdr_o[0]), .DDR1(ddr[0]), .PDR1I(PDR1I),
		.PDR2O(pdr_o[1]), .DDR2(ddr[1]), .PDR2I(PDR2I),
		.JOY1(joy[0]), .JOY2(joy[1]),
		.JOY1_X1(jx[0]), .JOY1_Y1(jy[0]), .JOY2_X1(jx[1]), .JOY2_Y1(jy[1]),
		.JOY1_TYPE(jtype[0]), .JOY2_TYPE(jtype[1])
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	// TH/TR as a 2-bit select
	function automatic logic [1:0] sel_of(input logic [`PAD_PIN_W-1:0] o);
		return {o[`PAD_TH_BIT], o[`PAD_TR_BIT]};
	endfunction

	// Nibbles in a full pass or zero for non-analog kinds
	function automatic int seq_len(input pad_type_e k);
		case (k)
			PAD_WHEEL: return 9;
			PAD_MISSION: return 13;
			PAD_3D: return 15;
			default: return 0;
		endcase
	endfunction

	// Nibble delivered on advance number idx
	function automatic logic [3:0] analog_nib(input pad_type_e k, input logic [15:0] b,
		input logic [7:0] x, input logic [7:0] y, input int idx);
		logic [3:0] n;
		n = 4'h0;
		if (k == PAD_WHEEL) begin
			case (idx)
				0: n = `PAD_ID_WHEEL;
				1, 2, 6: n = 4'hF;
				3: n = b[15:12];
				4: n = b[11:8];
				5: n = {1'b1, b[6:4]};
				7: n = x[7:4] ^ 4'h8;
				8: n = x[3:0];
				default: n = 4'h0;
			endcase
		end else begin
			case (idx)
				0, 1: n = `PAD_ID_ANALOG;
				2: n = (k == PAD_MISSION) ? `PAD_ID_MISSION : `PAD_ID_3D;
				3: n = b[15:12];
				4: n = b[11:8];
				5: n = b[7:4];
				6: n = b[3:0];
				7: n = x[7:4] ^ 4'h8;
				8: n = x[3:0];
				9: n = y[7:4] ^ 4'h8;
				10: n = y[3:0];
				// 3D pad trailer ends on 1
				14: n = 4'h1;
				default: n = 4'h0;
			endcase
		end
		return n;
	endfunction

	// Expected pin readback for one port
	function automatic logic [6:0] pin_expect(input logic [6:0] o, input logic [6:0] d,
		input pad_type_e k, input logic [15:0] b, input logic tl, input logic [3:0] nib);
		logic [6:0] v;
		for (int i = 0; i < 7; i++)
			v[i] = d[i] ? o[i] : 1'b1;
		if (k == PAD_DIGITAL && d[6:5] == 2'b10) begin
			v[3:0] = o[6] ? {b[3], 3'b100} : b[15:12];
		end else if (k == PAD_DIGITAL && d[6:5] == 2'b11) begin
			case (o[6:5])
				2'b00: v[3:0] = b[7:4];
				2'b01: v[3:0] = b[15:12];
				2'b10: v[3:0] = b[11:8];
				default: v[3:0] = {b[3], 3'b100};
			endcase
		end else if (k == PAD_WHEEL || k == PAD_MISSION || k == PAD_3D) begin
			v[4:0] = {tl, nib};
		end
		return v;
	endfunction

	// Sequencer model stepping only on clock enable
	always @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int p = 0; p < 2; p++) begin
				adv_cnt[p] <= 0;
				m_tl[p] <= 1'b1;
				m_nib[p] <= 4'h0;
			end
		end else if (SMPC_CE) begin
			for (int p = 0; p < 2; p++) begin
				if (seq_len(jtype[p]) > 0 && sel_of(pdr_o[p]) == 2'b11) begin
					adv_cnt[p] <= 0;
					m_tl[p] <= 1'b1;
					m_nib[p] <= (jtype[p] == PAD_WHEEL) ? 4'h0 : 4'h1;
				end else if (adv_cnt[p] < seq_len(jtype[p]) &&
					sel_of(pdr_o[p]) == ((adv_cnt[p] % 2 == 0) ? 2'b01 : 2'b00)) begin
					adv_cnt[p] <= adv_cnt[p] + 1;
					// 01 advances raise TL and 00 advances drop it
					m_tl[p] <= (adv_cnt[p] % 2 == 0);
					m_nib[p] <= analog_nib(jtype[p], joy[p], jx[p], jy[p], adv_cnt[p]);
				end
			end
		end
	end

	assign exp_pin[0] = pin_expect(pdr_o[0], ddr[0], jtype[0], joy[0], m_tl[0], m_nib[0]);
	assign exp_pin[1] = pin_expect(pdr_o[1], ddr[1], jtype[1], joy[1], m_tl[1], m_nib[1]);

	pin1_match: assert property (@(negedge CLK) PDR1I == exp_pin[0])
		else begin
			$display("[FAIL] %0t ns: port 1 pins %b, expected %b", $time, PDR1I, exp_pin[0]);
			pin_errors++;
		end

	pin2_match: assert property (@(negedge CLK) PDR2I == exp_pin[1])
		else begin
			$display("[FAIL] %0t ns: port 2 pins %b, expected %b", $time, PDR2I, exp_pin[1]);
			pin_errors++;
		end

	always @(posedge CLK) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// Check TL and nibble of one port against a named value
	task automatic expect_pins(input int p, input logic tl, input logic [3:0] nib,
		input string what);
		logic [6:0] got;
		got = (p == 0) ? PDR1I : PDR2I;
		assert (got[4:0] == {tl, nib})
			else begin
				$display("[FAIL] %0t ns: port %0d %s, got tl=%b nib=%h, expected tl=%b nib=%h",
					$time, p + 1, what, got[4], got[3:0], tl, nib);
				nib_errors++;
			end
	endtask

	// Hold select across one sampling edge and settle
	task automatic drive_sel(input logic [1:0] s1, input logic [1:0] s2);
		@(posedge CLK);
		pdr_o[0][6:5] <= s1;
		pdr_o[1][6:5] <= s2;
		@(posedge CLK);
		@(negedge CLK);
	endtask

	task automatic drive_random_pins();
		logic [31:0] r;
		@(posedge CLK);
		for (int p = 0; p < 2; p++) begin
			r = $random(seed);
			pdr_o[p] <= r[6:0];
			ddr[p] <= r[13:7];
			joy[p] <= r[31:16];
		end
		SMPC_CE <= r[14];
	endtask

	// Digital pad stimulus in a given select mode
	task automatic drive_digital(input logic [1:0] mode, input logic [1:0] s);
		logic [31:0] r;
		@(posedge CLK);
		for (int p = 0; p < 2; p++) begin
			r = $random(seed);
			joy[p] <= r[31:16];
			ddr[p] <= {mode, r[4:0]};
			pdr_o[p] <= {s, r[9:5]};
		end
	endtask

	task automatic load_pads(input pad_type_e k0, input pad_type_e k1);
		logic [31:0] r;
		@(posedge CLK);
		jtype[0] <= k0;
		jtype[1] <= k1;
		for (int p = 0; p < 2; p++) begin
			r = $random(seed);
			joy[p] <= r[15:0];
			jx[p] <= r[23:16];
			jy[p] <= r[31:24];
			// Host drives TH/TR only
			ddr[p] <= 7'h60;
		end
	endtask

	task automatic restart();
		drive_sel(2'b11, 2'b11);
		for (int p = 0; p < 2; p++)
			expect_pins(p, 1'b1, (jtype[p] == PAD_WHEEL) ? 4'h0 : 4'h1, "restart");
	endtask

	// Alternate 01/00 selects and check each pad id on the way
	task automatic walk(input int n);
		for (int k = 0; k < n; k++) begin
			drive_sel((k % 2 == 0) ? 2'b01 : 2'b00, (k % 2 == 0) ? 2'b01 : 2'b00);
			for (int p = 0; p < 2; p++) begin
				if (jtype[p] == PAD_WHEEL && k == 0)
					expect_pins(p, 1'b1, `PAD_ID_WHEEL, "wheel id");
				if (jtype[p] == PAD_MISSION && k == 2)
					expect_pins(p, 1'b1, `PAD_ID_MISSION, "mission id");
				if (jtype[p] == PAD_3D && k == 2)
					expect_pins(p, 1'b1, `PAD_ID_3D, "3D pad id");
			end
		end
	endtask

	// Last nibble after a full pass and extra selects
	task automatic check_ends();
		for (int p = 0; p < 2; p++) begin
			if (jtype[p] == PAD_WHEEL)
				expect_pins(p, 1'b1, jx[p][3:0], "wheel end");
			else if (jtype[p] == PAD_MISSION)
				expect_pins(p, 1'b1, 4'h0, "mission end");
			else
				expect_pins(p, 1'b1, 4'h1, "3D pad end");
		end
	endtask

	initial begin
		logic [4:0] held [2];
		seed = 17;
		pin_errors = 0;
		nib_errors = 0;
		cycles = 0;
		RST_N = 1'b0;
		SMPC_CE = 1'b0;
		for (int p = 0; p < 2; p++) begin
			pdr_o[p] = 7'h7F;
			ddr[p] = 7'h60;
			joy[p] = '1;
			jx[p] = '0;
			jy[p] = '0;
		end
		jtype[0] = PAD_WHEEL;
		jtype[1] = PAD_MISSION;

		// Reset values on analog ports
		@(negedge CLK);
		expect_pins(0, 1'b1, 4'h0, "in reset");
		expect_pins(1, 1'b1, 4'h0, "in reset");
		repeat (3) @(posedge CLK);
		RST_N <= 1'b1;
		@(negedge CLK);
		expect_pins(0, 1'b1, 4'h0, "after reset");
		expect_pins(1, 1'b1, 4'h0, "after reset");

		// Plain merge on empty port and mouse port
		@(posedge CLK);
		jtype[0] <= PAD_OFF;
		jtype[1] <= PAD_MOUSE;
		repeat (800) drive_random_pins();

		// Digital pad in three-wire then two-wire mode
		@(posedge CLK);
		jtype[0] <= PAD_DIGITAL;
		jtype[1] <= PAD_DIGITAL;
		repeat (150) begin
			for (int s = 0; s < 4; s++)
				drive_digital(2'b11, s[1:0]);
			drive_digital(2'b10, 2'b01);
			drive_digital(2'b10, 2'b11);
		end

		// Full passes of wheel and mission then mission against 3D pad
		@(posedge CLK);
		SMPC_CE <= 1'b1;
		load_pads(PAD_WHEEL, PAD_MISSION);
		restart();
		walk(15);
		check_ends();
		load_pads(PAD_MISSION, PAD_3D);
		restart();
		walk(15);
		check_ends();

		// Clock enable low freezes mid-sequence
		load_pads(PAD_WHEEL, PAD_3D);
		restart();
		walk(5);
		held[0] = PDR1I[4:0];
		held[1] = PDR2I[4:0];
		@(posedge CLK);
		SMPC_CE <= 1'b0;
		// Every select level including the awaited 00 and restart
		for (int s = 0; s < 4; s++) begin
			drive_sel(s[1:0], s[1:0]);
			expect_pins(0, held[0][4], held[0][3:0], "hold with CE low");
			expect_pins(1, held[1][4], held[1][3:0], "hold with CE low");
		end
		@(posedge CLK);
		SMPC_CE <= 1'b1;
		restart();
		walk(15);
		check_ends();

		repeat (2) @(posedge CLK);
		$display("Done: %0d pin mismatches, %0d nibble mismatches", pin_errors, nib_errors);
		if (pin_errors == 0 && nib_errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- flist.f
+incdir+include
hw/smpc_pad_pkg.sv
hw/pad_seq.sv
hw/pad_pin_drive.sv
hw/smpc_pad_top.sv
bench/tb_smpc_pad.sv

//--- hw/pad_pin_drive.sv
`timescale 1ns/1ps
`include "smpc_pad_cfg.svh"

module pad_pin_drive import smpc_pad_pkg::*; (
	input port_host_t host,
	input pad_input_t pad,
	input seq_out_t seq,
	output logic [`PAD_PIN_W-1:0] pdr_in
);

	logic th;
	logic tr;
	// DDR bits of TH/TR select the digital pad protocol
	logic [1:0] sel_mode;
	// Nibble carrying the pad id bits plus button L
	logic [`PAD_NIB_W-1:0] id_nib;

	assign th = host.pdr_out[`PAD_TH_BIT];
	assign tr = host.pdr_out[`PAD_TR_BIT];
	assign sel_mode = {host.ddr[`PAD_TH_BIT], host.ddr[`PAD_TR_BIT]};
	assign id_nib = {pad.buttons[3], 3'b100};

	always_comb begin
		// Open drain, undriven pins float high
		pdr_in = (host.pdr_out & host.ddr) | ~host.ddr;
		case (pad.kind)
			PAD_DIGITAL: begin
				if (sel_mode == 2'b10) begin
					// Two-wire mode, TH alone selects
					if (th)
						pdr_in[3:0] = id_nib;
					else
						pdr_in[3:0] = pad.buttons[15:12];
				end else if (sel_mode == 2'b11) begin
					// Three-wire mode, TH/TR select one of four
					case ({th, tr})
						2'b00: pdr_in[3:0] = pad.buttons[7:4];
						2'b01: pdr_in[3:0] = pad.buttons[15:12];
						2'b10: pdr_in[3:0] = pad.buttons[11:8];
						default: pdr_in[3:0] = id_nib;
					endcase
				end
			end

			// Sequencer owns TL and data pins
			PAD_WHEEL,
			PAD_MISSION,
			PAD_3D: begin
				pdr_in[4:0] = {seq.tl, seq.nibble};
			end

			// Empty port, mouse and dual mission keep the plain merge
			default: ;
		endcase
	end

endmodule

//--- hw/pad_seq.sv
`timescale 1ns/1ps
`include "smpc_pad_cfg.svh"

module pad_seq import smpc_pad_pkg::*; (
	input CLK,
	input RST_N,
	input logic smpc_ce,
	// {TH, TR} as driven by the host
	input logic [1:0] sel,
	input pad_input_t pad,
	output seq_out_t seq
);

	seq_step_e step;
	seq_step_e step_nxt;
	seq_step_e step_last;
	logic analog;
	logic is_wheel;
	logic [1:0] sel_req;
	logic adv;
	logic [`PAD_NIB_W-1:0] nib_adv;
	logic [`PAD_NIB_W-1:0] nib_restart;
	logic [`PAD_NIB_W-1:0] pad_id;
	logic [`PAD_NIB_W-1:0] x_hi;
	logic [`PAD_NIB_W-1:0] x_lo;
	logic [`PAD_NIB_W-1:0] y_hi;
	logic [`PAD_NIB_W-1:0] y_lo;

	// Axis nibbles, high half re-biased so centre reads as 8
	assign x_hi = pad.axis_x[7:4] ^ 4'h8;
	assign x_lo = pad.axis_x[3:0];
	assign y_hi = pad.axis_y[7:4] ^ 4'h8;
	assign y_lo = pad.axis_y[3:0];

	assign is_wheel = (pad.kind == PAD_WHEEL);

	// Per-kind sequence length, id and restart value
	always_comb begin
		analog = 1'b1;
		step_last = STEP_0;
		pad_id = `PAD_ID_ANALOG;
		nib_restart = `PAD_ID_ANALOG;
		case (pad.kind)
			PAD_WHEEL: begin
				step_last = STEP_10;
				pad_id = `PAD_ID_WHEEL;
				nib_restart = 4'h0;
			end
			PAD_MISSION: begin
				step_last = STEP_14;
				pad_id = `PAD_ID_MISSION;
			end
			PAD_3D: begin
				step_last = STEP_16;
				pad_id = `PAD_ID_3D;
			end
			// Digital, empty, mouse, dual mission
			default: analog = 1'b0;
		endcase
	end

	// STEP_0/1 and odd steps wait for 01, even steps from 2 on wait for 00
	assign sel_req = {1'b0, step[0] | (step == STEP_0)};

	// Both idle steps jump straight to STEP_2
	always_comb begin
		if (step == STEP_0 || step == STEP_1)
			step_nxt = STEP_2;
		else if (step == STEP_16)
			step_nxt = STEP_16;
		else
			step_nxt = seq_step_e'(step + 5'd1);
	end

	// Advance only below the last step of this pad kind
	assign adv = analog && (sel == sel_req) && (step < step_last);

	// Nibble presented once the new step is reached
	always_comb begin
		nib_adv = 4'h0;
		if (is_wheel) begin
			case (step_nxt)
				STEP_2: nib_adv = pad_id;
				// Filler nibbles
				STEP_3, STEP_4, STEP_8: nib_adv = {`PAD_NIB_W{1'b1}};
				STEP_5: nib_adv = pad.buttons[15:12];
				STEP_6: nib_adv = pad.buttons[11:8];
				// Wheel drops button bit 7
				STEP_7: nib_adv = {1'b1, pad.buttons[6:4]};
				STEP_9: nib_adv = x_hi;
				STEP_10: nib_adv = x_lo;
				default: nib_adv = 4'h0;
			endcase
		end else begin
			case (step_nxt)
				// Analog marker twice, then the pad id
				STEP_2, STEP_3: nib_adv = `PAD_ID_ANALOG;
				STEP_4: nib_adv = pad_id;
				STEP_5: nib_adv = pad.buttons[15:12];
				STEP_6: nib_adv = pad.buttons[11:8];
				STEP_7: nib_adv = pad.buttons[7:4];
				STEP_8: nib_adv = pad.buttons[3:0];
				STEP_9: nib_adv = x_hi;
				STEP_10: nib_adv = x_lo;
				STEP_11: nib_adv = y_hi;
				STEP_12: nib_adv = y_lo;
				// Trailing bytes, 3D pad only past STEP_14
				STEP_16: nib_adv = 4'h1;
				default: nib_adv = 4'h0;
			endcase
		end
	end

	// Step and pin registers, only move on SMPC clock enable
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			step <= STEP_0;
			seq.tl <= 1'b1;
			seq.nibble <= '0;
		end else if (smpc_ce && analog) begin
			if (sel == 2'b11) begin
				// TH and TR high ends any transfer
				step <= STEP_0;
				seq.tl <= 1'b1;
				seq.nibble <= nib_restart;
			end else if (adv) begin
				step <= step_nxt;
				// TL echoes TR, toggles every handshake
				seq.tl <= sel[0];
				seq.nibble <= nib_adv;
			end
		end
	end

endmodule

//--- hw/smpc_pad_pkg.sv
`include "smpc_pad_cfg.svh"

package smpc_pad_pkg;

	// Pad kind as selected by the system, one per port
	typedef enum logic [2:0] {
		PAD_DIGITAL = 3'd0,
		PAD_OFF = 3'd1,
		PAD_WHEEL = 3'd2,
		PAD_MISSION = 3'd3,
		PAD_3D = 3'd4,
		// Kept for encoding only, handled like an empty port
		PAD_DUALMISSION = 3'd5,
		PAD_MOUSE = 3'd6
	} pad_type_e;

	// Analog sequencer position
	typedef enum logic [4:0] {
		STEP_0, STEP_1, STEP_2, STEP_3, STEP_4, STEP_5,
		STEP_6, STEP_7, STEP_8, STEP_9, STEP_10, STEP_11,
		STEP_12, STEP_13, STEP_14, STEP_15, STEP_16
	} seq_step_e;

	// Everything the attached pad presents
	typedef struct packed {
		logic [`PAD_BTN_W-1:0] buttons;
		logic [`PAD_AXIS_W-1:0] axis_x;
		logic [`PAD_AXIS_W-1:0] axis_y;
		pad_type_e kind;
	} pad_input_t;

	// Host side of one port
	typedef struct packed {
		logic [`PAD_PIN_W-1:0] pdr_out;
		logic [`PAD_PIN_W-1:0] ddr;
	} port_host_t;

	// Sequencer contribution to pins 4:0
	typedef struct packed {
		logic tl;
		logic [`PAD_NIB_W-1:0] nibble;
	} seq_out_t;

endpackage

//--- hw/smpc_pad_top.sv
`timescale 1ns/1ps
`include "smpc_pad_cfg.svh"

module smpc_pad_top import smpc_pad_pkg::*; (
	input CLK,
	input RST_N,
	input logic SMPC_CE,

	// Port 1 host registers
	input logic [`PAD_PIN_W-1:0] PDR1O,
	input logic [`PAD_PIN_W-1:0] DDR1,
	output logic [`PAD_PIN_W-1:0] PDR1I,
	// Port 2 host registers
	input logic [`PAD_PIN_W-1:0] PDR2O,
	input logic [`PAD_PIN_W-1:0] DDR2,
	output logic [`PAD_PIN_W-1:0] PDR2I,

	// Pad state, buttons active low
	input logic [`PAD_BTN_W-1:0] JOY1,
	input logic [`PAD_BTN_W-1:0] JOY2,
	input logic [`PAD_AXIS_W-1:0] JOY1_X1,
	input logic [`PAD_AXIS_W-1:0] JOY1_Y1,
	input logic [`PAD_AXIS_W-1:0] JOY2_X1,
	input logic [`PAD_AXIS_W-1:0] JOY2_Y1,
	input logic [2:0] JOY1_TYPE,
	input logic [2:0] JOY2_TYPE
);

	port_host_t host1;
	port_host_t host2;
	pad_input_t pad1;
	pad_input_t pad2;
	seq_out_t seq1;
	seq_out_t seq2;

	assign host1 = '{pdr_out: PDR1O, ddr: DDR1};
	assign host2 = '{pdr_out: PDR2O, ddr: DDR2};

	assign pad1 = '{buttons: JOY1, axis_x: JOY1_X1, axis_y: JOY1_Y1,
		kind: pad_type_e'(JOY1_TYPE)};
	assign pad2 = '{buttons: JOY2, axis_x: JOY2_X1, axis_y: JOY2_Y1,
		kind: pad_type_e'(JOY2_TYPE)};

	// Sequencers take TH/TR straight from the data register
	pad_seq u_seq1 (
		.CLK(CLK),
		.RST_N(RST_N),
		.smpc_ce(SMPC_CE),
		.sel({PDR1O[`PAD_TH_BIT], PDR1O[`PAD_TR_BIT]}),
		.pad(pad1),
		.seq(seq1)
	);

	pad_seq u_seq2 (
		.CLK(CLK),
		.RST_N(RST_N),
		.smpc_ce(SMPC_CE),
		.sel({PDR2O[`PAD_TH_BIT], PDR2O[`PAD_TR_BIT]}),
		.pad(pad2),
		.seq(seq2)
	);

	// Pin readback per port
	pad_pin_drive u_drive1 (
		.host(host1),
		.pad(pad1),
		.seq(seq1),
		.pdr_in(PDR1I)
	);

	pad_pin_drive u_drive2 (
		.host(host2),
		.pad(pad2),
		.seq(seq2),
		.pdr_in(PDR2I)
	);

endmodule

//--- include/smpc_pad_cfg.svh
`ifndef SMPC_PAD_CFG_SVH
`define SMPC_PAD_CFG_SVH

// Port pin count, TH/TR/TL/D3..D0
`define PAD_PIN_W 7
// One data nibble on D3..D0
`define PAD_NIB_W 4
// Button word, active low
`define PAD_BTN_W 16
// Analog axis, two's complement, zero at centre
`define PAD_AXIS_W 8

// Select line positions inside PDR/DDR
`define PAD_TH_BIT 6
`define PAD_TR_BIT 5

// Identification nibbles sent by the analog pads
`define PAD_ID_WHEEL 4'hB
`define PAD_ID_ANALOG 4'h1
`define PAD_ID_MISSION 4'h5
`define PAD_ID_3D 4'h6

`endif
